//--- hw/iq_frame_pkg.sv
`default_nettype none

package iq_frame_pkg;

  // ==============================
  // Word and frame layout
  // ==============================
  localparam int WORD_WIDTH     = 32;  // One I/Q sample word
  localparam int PAIRS_PER_WORD = 16;  // DDR pairs making up one word
  localparam int Q_SYNC_INDEX   = 8;   // Pair that opens the Q half

  // Pair counter width, derived from the frame length
  localparam int PAIR_IDX_WIDTH = $clog2(PAIRS_PER_WORD);

  // Sync patterns as {d0, d1}, d0 arrives first
  localparam logic [1:0] I_SYNC_PAIR = 2'b10;  // d0 high, d1 low
  localparam logic [1:0] Q_SYNC_PAIR = 2'b01;  // d0 low, d1 high

  // ==============================
  // Types
  // ==============================
  typedef enum logic {
    BAND_RX09 = 1'b0,  // Sub-GHz receiver, true polarity
    BAND_RX24 = 1'b1   // 2.4 GHz receiver, inverted on the board
  } band_e;

  typedef enum logic [1:0] {
    DF_HUNT   = 2'd0,  // Waiting for the I sync pair
    DF_I_HALF = 2'd1,  // Pairs 1..7
    DF_Q_HALF = 2'd2   // Pairs 8..15, pair 8 must be Q sync
  } deframe_state_e;

endpackage

`default_nettype wire

//--- hw/smi_pkg.sv
`default_nettype none

package smi_pkg;

  // ==============================
  // SMI byte layout
  // ==============================
  localparam int BYTES_PER_WORD = 4;  // MSB first on the bus
  localparam int BYTE_WIDTH     = 8;  // Width of the SMI data bus

  localparam int BYTE_IDX_WIDTH = $clog2(BYTES_PER_WORD);

  // Level of the a2 line when the FPGA drives the host
  localparam logic DIR_TO_HOST = 1'b1;

  // Host read strobe tracking
  typedef enum logic [1:0] {
    RD_IDLE        = 2'd0,  // Waiting for a strobe on a valid word
    RD_STROBE_LOW  = 2'd1,  // Host is sampling the current byte
    RD_STROBE_HIGH = 2'd2   // Byte done, one cycle of settling
  } readout_state_e;

endpackage

`default_nettype wire

//--- hw/iq_deframer.sv
`timescale 1ns/10ps
`default_nettype none

module iq_deframer (
  input  wire                                   i_glob_clock,
  input  wire                                   i_rst_b,
  input  wire                                   i_rx_09_d0,  // Earlier bit of the pair
  input  wire                                   i_rx_09_d1,
  input  wire                                   i_rx_24_d0,  // Inverted on the board
  input  wire                                   i_rx_24_d1,
  input  iq_frame_pkg::band_e                   i_band,
  input  wire                                   i_full,
  output logic                                  o_push,
  output logic [iq_frame_pkg::WORD_WIDTH-1:0]   o_word
);

  localparam int IDX_W = iq_frame_pkg::PAIR_IDX_WIDTH;

  // Pair indices where the FSM changes half or closes the frame
  localparam logic [IDX_W-1:0] LAST_I_PAIR = IDX_W'(iq_frame_pkg::Q_SYNC_INDEX - 1);
  localparam logic [IDX_W-1:0] Q_PAIR      = IDX_W'(iq_frame_pkg::Q_SYNC_INDEX);
  localparam logic [IDX_W-1:0] LAST_PAIR   = IDX_W'(iq_frame_pkg::PAIRS_PER_WORD - 1);

  // ==============================
  // Band select and polarity
  // ==============================
  logic [1:0]                        w_pair;        // Corrected pair {d0, d1}
  logic                              w_band_change;
  iq_frame_pkg::band_e               r_band_q;      // Band seen last cycle
  iq_frame_pkg::deframe_state_e      r_state;
  logic [IDX_W-1:0]                  r_pair_idx;    // Index of the incoming pair
  logic [iq_frame_pkg::WORD_WIDTH-1:0] r_word;

  // RX24 pins carry the complement, undo it before any sync test
  assign w_pair = (i_band == iq_frame_pkg::BAND_RX24) ? ~{i_rx_24_d0, i_rx_24_d1}
                                                      :  {i_rx_09_d0, i_rx_09_d1};

  assign w_band_change = (i_band != r_band_q);

  // ==============================
  // Word assembly
  // ==============================
  // Shift every cycle, the register always holds the last 16 pairs
  // so the I sync pair ends up in bits 31:30 after pair 15
  always_ff @(posedge i_glob_clock) begin
    r_word <= {r_word[iq_frame_pkg::WORD_WIDTH-3:0], w_pair};
  end

  assign o_word = r_word;

  // ==============================
  // Sync FSM
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_state    <= iq_frame_pkg::DF_HUNT;
      r_pair_idx <= '0;
      r_band_q   <= iq_frame_pkg::BAND_RX09;
      o_push     <= 1'b0;
    end else begin
      r_band_q <= i_band;
      o_push   <= 1'b0;  // Single-cycle pulse

      if (w_band_change) begin
        // Source switched mid-stream, whatever was collected is junk
        r_state    <= iq_frame_pkg::DF_HUNT;
        r_pair_idx <= '0;
      end else begin
        case (r_state)
          iq_frame_pkg::DF_HUNT: begin
            if (w_pair == iq_frame_pkg::I_SYNC_PAIR) begin
              r_state    <= iq_frame_pkg::DF_I_HALF;  // This was pair 0
              r_pair_idx <= IDX_W'(1);
            end
          end

          iq_frame_pkg::DF_I_HALF: begin
            r_pair_idx <= r_pair_idx + 1'b1;
            if (r_pair_idx == LAST_I_PAIR) begin
              r_state <= iq_frame_pkg::DF_Q_HALF;
            end
          end

          iq_frame_pkg::DF_Q_HALF: begin
            r_pair_idx <= r_pair_idx + 1'b1;
            if ((r_pair_idx == Q_PAIR) && (w_pair != iq_frame_pkg::Q_SYNC_PAIR)) begin
              r_state    <= iq_frame_pkg::DF_HUNT;  // Q sync missing, drop frame
              r_pair_idx <= '0;
            end else if (r_pair_idx == LAST_PAIR) begin
              r_state    <= iq_frame_pkg::DF_HUNT;
              r_pair_idx <= '0;
              o_push     <= !i_full;  // No room, the whole word is lost
            end
          end

          default: begin
            r_state    <= iq_frame_pkg::DF_HUNT;
            r_pair_idx <= '0;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo #(
  parameter int FIFO_ADDR_WIDTH = 4,                        // 2**N words deep
  parameter int WORD_WIDTH      = iq_frame_pkg::WORD_WIDTH
) (
  input  wire                   i_glob_clock,
  input  wire                   i_rst_b,
  input  wire                   i_push,
  input  wire  [WORD_WIDTH-1:0] i_word,
  input  wire                   i_pull,
  output logic [WORD_WIDTH-1:0] o_head_word,  // Valid whenever not empty
  output logic                  o_full,
  output logic                  o_empty
);

  localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

  // ==============================
  // Storage and pointers
  // ==============================
  logic [WORD_WIDTH-1:0]    r_mem [0:DEPTH-1];
  logic [FIFO_ADDR_WIDTH:0] r_wr_ptr;  // Extra MSB is the wrap flag
  logic [FIFO_ADDR_WIDTH:0] r_rd_ptr;
  logic                     w_do_push;
  logic                     w_do_pull;
  logic                     w_same_addr;

  assign w_same_addr = (r_wr_ptr[FIFO_ADDR_WIDTH-1:0] == r_rd_ptr[FIFO_ADDR_WIDTH-1:0]);

  // Same address, wrap flags tell full from empty
  assign o_empty = w_same_addr && (r_wr_ptr[FIFO_ADDR_WIDTH] == r_rd_ptr[FIFO_ADDR_WIDTH]);
  assign o_full  = w_same_addr && (r_wr_ptr[FIFO_ADDR_WIDTH] != r_rd_ptr[FIFO_ADDR_WIDTH]);

  assign w_do_push = i_push && !o_full;   // Push into a full FIFO is lost
  assign w_do_pull = i_pull && !o_empty;  // Pull on empty is ignored

  // ==============================
  // Write side
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (w_do_push) begin
      r_mem[r_wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= i_word;
    end
  end

  // ==============================
  // Pointer update
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (w_do_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_do_pull) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;  // Next word falls through
      end
    end
  end

  // First word fall through, head is read straight from the array
  assign o_head_word = r_mem[r_rd_ptr[FIFO_ADDR_WIDTH-1:0]];

endmodule

`default_nettype wire

//--- hw/smi_readout.sv
`timescale 1ns/10ps
`default_nettype none

module smi_readout (
  input  wire                                 i_glob_clock,
  input  wire                                 i_rst_b,
  input  wire  [iq_frame_pkg::WORD_WIDTH-1:0] i_head_word,  // FWFT head of the FIFO
  input  wire                                 i_empty,
  input  wire                                 i_smi_a2,     // Bus direction
  input  wire                                 i_smi_soe_se, // Read strobe, active low
  output logic                                o_pull,
  output logic [smi_pkg::BYTE_WIDTH-1:0]      o_smi_data,
  output logic                                o_smi_data_oe,
  output logic                                o_smi_read_req
);

  localparam int IDX_W = smi_pkg::BYTE_IDX_WIDTH;

  localparam logic [IDX_W-1:0] LAST_BYTE = IDX_W'(smi_pkg::BYTES_PER_WORD - 1);

  // ==============================
  // Strobe tracking
  // ==============================
  logic                     r_soe_q;     // Strobe after one register
  smi_pkg::readout_state_e  r_state;
  logic [IDX_W-1:0]         r_byte_idx;  // 0 is the most significant byte
  logic                     w_to_host;
  logic                     w_byte_done;

  assign w_to_host = (i_smi_a2 == smi_pkg::DIR_TO_HOST);

  // Registered strobe went back high while a byte was out
  assign w_byte_done = (r_state == smi_pkg::RD_STROBE_LOW) && r_soe_q;

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_soe_q    <= 1'b1;  // Idle level of the strobe
      r_state    <= smi_pkg::RD_IDLE;
      r_byte_idx <= '0;
    end else begin
      r_soe_q <= i_smi_soe_se;

      case (r_state)
        smi_pkg::RD_IDLE: begin
          // Only count strobes that really read a word
          if (!r_soe_q && w_to_host && !i_empty) begin
            r_state <= smi_pkg::RD_STROBE_LOW;
          end
        end

        smi_pkg::RD_STROBE_LOW: begin
          if (w_byte_done) begin
            r_state    <= smi_pkg::RD_STROBE_HIGH;
            r_byte_idx <= r_byte_idx + 1'b1;  // Wraps to 0 after the last byte
          end
        end

        smi_pkg::RD_STROBE_HIGH: begin
          r_state <= smi_pkg::RD_IDLE;  // Gives the FIFO head a cycle to settle
        end

        default: begin
          r_state <= smi_pkg::RD_IDLE;
        end
      endcase
    end
  end

  // Word consumed, advance the FIFO on the same edge as the index wrap
  assign o_pull = w_byte_done && (r_byte_idx == LAST_BYTE);

  // ==============================
  // Bus outputs
  // ==============================
  // MSB first, index 0 selects bits 31:24
  assign o_smi_data = i_head_word[(smi_pkg::BYTES_PER_WORD - 1 - int'(r_byte_idx))
                                  * smi_pkg::BYTE_WIDTH +: smi_pkg::BYTE_WIDTH];

  assign o_smi_read_req = w_to_host && !i_empty;      // Data waiting for the host
  assign o_smi_data_oe  = w_to_host && !i_smi_soe_se; // Drive only during the strobe

endmodule

`default_nettype wire

//--- hw/iq_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module iq_rx_top #(
  parameter int FIFO_ADDR_WIDTH = 4,                        // 16 words
  parameter int WORD_WIDTH      = iq_frame_pkg::WORD_WIDTH
) (
  input  wire                            i_glob_clock,
  input  wire                            i_rst_b,
  input  wire                            i_rx_09_d0,
  input  wire                            i_rx_09_d1,
  input  wire                            i_rx_24_d0,
  input  wire                            i_rx_24_d1,
  input  wire                            i_smi_a3,      // Band select
  input  wire                            i_smi_a2,      // Direction
  input  wire                            i_smi_soe_se,
  output logic [smi_pkg::BYTE_WIDTH-1:0] o_smi_data,
  output logic                           o_smi_data_oe,
  output logic                           o_smi_read_req
);

  // ==============================
  // Inter-stage wires
  // ==============================
  iq_frame_pkg::band_e   w_band;
  logic                  w_push;
  logic [WORD_WIDTH-1:0] w_word;
  logic                  w_full;
  logic [WORD_WIDTH-1:0] w_head_word;
  logic                  w_empty;
  logic                  w_pull;

  assign w_band = iq_frame_pkg::band_e'(i_smi_a3);  // a3 low is RX09

  // Stage 1, DDR pairs to words
  iq_deframer u_deframer (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_rx_09_d0   (i_rx_09_d0),
    .i_rx_09_d1   (i_rx_09_d1),
    .i_rx_24_d0   (i_rx_24_d0),
    .i_rx_24_d1   (i_rx_24_d1),
    .i_band       (w_band),
    .i_full       (w_full),
    .o_push       (w_push),
    .o_word       (w_word)
  );

  // Stage 2, word buffer
  sample_fifo #(
    .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH),
    .WORD_WIDTH      (WORD_WIDTH)
  ) u_sample_fifo (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_push       (w_push),
    .i_word       (w_word),
    .i_pull       (w_pull),
    .o_head_word  (w_head_word),
    .o_full       (w_full),
    .o_empty      (w_empty)
  );

  // Stage 3, bytes to the SMI host
  smi_readout u_smi_readout (
    .i_glob_clock   (i_glob_clock),
    .i_rst_b        (i_rst_b),
    .i_head_word    (w_head_word),
    .i_empty        (w_empty),
    .i_smi_a2       (i_smi_a2),
    .i_smi_soe_se   (i_smi_soe_se),
    .o_pull         (w_pull),
    .o_smi_data     (o_smi_data),
    .o_smi_data_oe  (o_smi_data_oe),
    .o_smi_read_req (o_smi_read_req)
  );

endmodule

`default_nettype wire

//--- test/iq_rx_checker.sv
`timescale 1ns/10ps
`default_nettype none

module iq_rx_checker (
  input  wire       i_glob_clock,
  input  wire       i_rst_b,
  input  wire       i_smi_soe_se,    // Strobe pin as the host drives it
  input  wire [7:0] i_smi_data,
  input  wire       i_smi_data_oe,
  input  wire       i_smi_read_req,
  input  wire       i_exp_valid,     // Byte compare armed for the current strobe
  input  wire [7:0] i_exp_byte,
  input  wire       i_lvl_check,     // Compare request and bus enable this cycle
  input  wire       i_exp_read_req,
  input  wire       i_exp_data_oe,
  output int        o_check_count,
  output int        o_error_count
);

  logic r_soe_q;   // Strobe registered once, as inside the readout
  logic r_soe_qq;  // One more stage to find its rising edge

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_soe_q  <= 1'b1;
      r_soe_qq <= 1'b1;
    end else begin
      r_soe_q  <= i_smi_soe_se;
      r_soe_qq <= r_soe_q;
    end
  end

  // ==============================
  // Compares, half a cycle after the edge
  // ==============================
  always @(negedge i_glob_clock) begin : compare_blk
    int n_chk;
    int n_err;
    n_chk = 0;
    n_err = 0;
    if (i_exp_valid && r_soe_q && !r_soe_qq) begin  // Registered strobe just rose
      n_chk = n_chk + 1;
      if (i_smi_data !== i_exp_byte) begin
        $display("[FAIL] t=%0t SMI byte expected %02h got %02h", $time, i_exp_byte, i_smi_data);
        n_err = n_err + 1;
      end
    end
    if (i_lvl_check) begin
      n_chk = n_chk + 1;
      if ((i_smi_read_req !== i_exp_read_req) || (i_smi_data_oe !== i_exp_data_oe)) begin
        $display("[FAIL] t=%0t read_req/data_oe expected %0b/%0b got %0b/%0b", $time,
                 i_exp_read_req, i_exp_data_oe, i_smi_read_req, i_smi_data_oe);
        n_err = n_err + 1;
      end
    end
    if (!i_rst_b) begin
      o_check_count <= 0;
      o_error_count <= 0;
    end else begin
      o_check_count <= o_check_count + n_chk;
      o_error_count <= o_error_count + n_err;
    end
  end

endmodule

`default_nettype wire

//--- test/tb_iq_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_iq_rx_top;

  localparam int FIFO_ADDR_WIDTH = 4;
  localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_WIDTH;  // Words kept while nobody reads
  localparam int NUM_TESTS       = 5;
  localparam int WAIT_LIMIT      = 200;                   // Cycles per wait for a request

  typedef struct packed {
    iq_frame_pkg::band_e band;
    int                  n_frames;
    logic [31:0]         base;        // Seed word mixed with the LCG
    logic                corrupt;     // Frame 1 loses its Q half
    logic                read_early;  // Read each word before the next frame
  } test_row_t;

  logic       glob_clock;
  logic       rst_b;
  logic       rx_09_d0;
  logic       rx_09_d1;
  logic       rx_24_d0;
  logic       rx_24_d1;
  logic       smi_a3;
  logic       smi_a2;
  logic       smi_soe_se;
  logic [7:0] smi_data;
  logic       smi_data_oe;
  logic       smi_read_req;
  logic       exp_valid;
  logic [7:0] exp_byte;
  logic       lvl_check;
  logic       exp_read_req;
  logic       exp_data_oe;
  int         check_count;
  int         error_count;

  test_row_t   test_table [0:NUM_TESTS-1];
  test_row_t   row;
  logic [31:0] exp_words [$];  // Words the FIFO must hand out in order
  logic [31:0] lcg_state;
  logic [31:0] word;
  logic        bad;
  int          t;
  int          f;
  int          tb_errors;      // Timeouts while waiting on the DUT
  int          chk_base;
  int          err_base;
  int          tb_base;

  iq_rx_top #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) i_iq_rx_top (
    .i_glob_clock (glob_clock), .i_rst_b (rst_b),
    .i_rx_09_d0 (rx_09_d0), .i_rx_09_d1 (rx_09_d1),
    .i_rx_24_d0 (rx_24_d0), .i_rx_24_d1 (rx_24_d1),
    .i_smi_a3 (smi_a3), .i_smi_a2 (smi_a2), .i_smi_soe_se (smi_soe_se),
    .o_smi_data (smi_data), .o_smi_data_oe (smi_data_oe), .o_smi_read_req (smi_read_req)
  );

  iq_rx_checker u_checker (
    .i_glob_clock (glob_clock), .i_rst_b (rst_b), .i_smi_soe_se (smi_soe_se),
    .i_smi_data (smi_data), .i_smi_data_oe (smi_data_oe), .i_smi_read_req (smi_read_req),
    .i_exp_valid (exp_valid), .i_exp_byte (exp_byte), .i_lvl_check (lvl_check),
    .i_exp_read_req (exp_read_req), .i_exp_data_oe (exp_data_oe),
    .o_check_count (check_count), .o_error_count (error_count)
  );

  initial begin
    glob_clock = 1'b0;
    forever #50 glob_clock = ~glob_clock;  // 100 ns period
  end

  // ==============================
  // Stimulus helpers
  // ==============================
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] make_word(input logic [31:0] base, input logic corrupt);
    logic [31:0] w;
    lcg_state = lcg_next(lcg_state);
    w = base ^ lcg_state;
    w[31:30] = iq_frame_pkg::I_SYNC_PAIR;  // Pair 0 opens every frame
    if (corrupt) begin
      w[15:0] = '0;                        // Pairs 8..15 zero so no Q sync
    end else begin
      w[15:14] = iq_frame_pkg::Q_SYNC_PAIR;
    end
    return w;
  endfunction

  task automatic step();
    @(posedge glob_clock);
    #10;  // Inputs move just after the edge
  endtask

  task automatic set_idle();
    rx_09_d0 = 1'b0;
    rx_09_d1 = 1'b0;
    rx_24_d0 = 1'b1;  // Idle is 0 after the board inversion
    rx_24_d1 = 1'b1;
  endtask

  task automatic send_frame(input iq_frame_pkg::band_e band, input logic [31:0] w);
    int p;
    for (p = 0; p < iq_frame_pkg::PAIRS_PER_WORD; p++) begin
      if (band == iq_frame_pkg::BAND_RX24) begin
        rx_24_d0 = ~w[31 - 2*p];  // Pins carry the complement
        rx_24_d1 = ~w[30 - 2*p];
      end else begin
        rx_09_d0 = w[31 - 2*p];   // d0 is the earlier bit
        rx_09_d1 = w[30 - 2*p];
      end
      step();
    end
    set_idle();
    repeat (4) step();            // Gap between frames
  endtask

  task automatic check_levels(input logic req, input logic oe);
    exp_read_req = req;
    exp_data_oe  = oe;
    lvl_check    = 1'b1;
    step();
    lvl_check    = 1'b0;
  endtask

  // Host read cycle with the strobe low for 2 cycles then high for 2
  task automatic host_read_byte(input logic chk, input logic [7:0] b, input logic req,
                                input logic oe);
    smi_soe_se   = 1'b0;
    exp_valid    = chk;
    exp_byte     = b;
    exp_read_req = req;
    exp_data_oe  = oe;
    lvl_check    = 1'b1;
    step();
    lvl_check    = 1'b0;
    step();
    smi_soe_se   = 1'b1;  // Byte sampled by the checker on the registered edge
    repeat (2) step();
  endtask

  task automatic wait_read_req(output logic got);
    int cycles;
    cycles = 0;
    while (!smi_read_req && (cycles < WAIT_LIMIT)) begin
      step();
      cycles++;
    end
    got = smi_read_req;
    if (!got) begin
      $display("Timed out after %0d cycles waiting for the read request at %0t",
               WAIT_LIMIT, $time);
      tb_errors++;
    end
  endtask

  task automatic read_word(input logic [31:0] w);
    int   b;
    logic got;
    wait_read_req(got);
    if (got) begin
      for (b = 0; b < smi_pkg::BYTES_PER_WORD; b++) begin
        host_read_byte(1'b1, w[31 - 8*b -: 8], 1'b1, 1'b1);  // MSB first
      end
    end
  endtask

  task automatic report_test(input int num, input string what);
    $display("Test %0d %s: %0d checks, %0d mismatches, %0d other errors", num, what,
             check_count - chk_base, error_count - err_base, tb_errors - tb_base);
    chk_base = check_count;
    err_base = error_count;
    tb_base  = tb_errors;
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    rst_b = 1'b0;
    smi_a3 = 1'b0;
    smi_a2 = 1'b0;
    smi_soe_se = 1'b1;
    set_idle();
    exp_valid = 1'b0;
    exp_byte = 8'h00;
    lvl_check = 1'b0;
    exp_read_req = 1'b0;
    exp_data_oe = 1'b0;
    lcg_state = 32'd29;
    tb_errors = 0;
    chk_base = 0;
    err_base = 0;
    tb_base = 0;
    //                 band                      frames  base          bad   early
    test_table[0] = '{iq_frame_pkg::BAND_RX09,  3, 32'h1234_5678, 1'b0, 1'b0};
    test_table[1] = '{iq_frame_pkg::BAND_RX24,  3, 32'hA5C3_0F96, 1'b0, 1'b0};
    test_table[2] = '{iq_frame_pkg::BAND_RX09,  3, 32'h0BAD_F00D, 1'b1, 1'b0};
    test_table[3] = '{iq_frame_pkg::BAND_RX24,  3, 32'h7E57_1D1E, 1'b1, 1'b1};
    test_table[4] = '{iq_frame_pkg::BAND_RX09, 20, 32'hC0DE_CAFE, 1'b0, 1'b0};
    repeat (5) @(posedge glob_clock);
    #10;
    rst_b = 1'b1;

    // Reset levels then a word held back by the direction line
    smi_a2 = 1'b1;
    check_levels(1'b0, 1'b0);
    smi_a2 = 1'b0;
    word = make_word(32'h5A5A_0000, 1'b0);
    send_frame(iq_frame_pkg::BAND_RX09, word);
    check_levels(1'b0, 1'b0);
    host_read_byte(1'b0, 8'h00, 1'b0, 1'b0);  // Strobe with a2 low keeps the bus off
    smi_a2 = 1'b1;
    read_word(word);
    check_levels(1'b0, 1'b0);
    report_test(0, "reset and idle");

    for (t = 0; t < NUM_TESTS; t++) begin
      row = test_table[t];
      smi_a3 = row.band;  // Band moves only while the pins idle
      repeat (2) step();
      for (f = 0; f < row.n_frames; f++) begin
        bad = row.corrupt && (f == 1);
        word = make_word(row.base, bad);
        send_frame(row.band, word);
        if (!bad && row.read_early) begin
          read_word(word);
        end else if (!bad && (exp_words.size() < FIFO_DEPTH)) begin
          exp_words.push_back(word);  // Later words are dropped at the full FIFO
        end
      end
      while (exp_words.size() > 0) begin
        word = exp_words.pop_front();
        read_word(word);
      end
      check_levels(1'b0, 1'b0);  // Nothing left for the host
      report_test(t + 1, $sformatf("%s, %0d frames",
                  (row.band == iq_frame_pkg::BAND_RX24) ? "RX24" : "RX09", row.n_frames));
    end

    $display("Totals: %0d checks, %0d mismatches, %0d other errors",
             check_count, error_count, tb_errors);
    if ((error_count == 0) && (tb_errors == 0) && (check_count > 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hw/iq_frame_pkg.sv
hw/smi_pkg.sv
hw/iq_deframer.sv
hw/sample_fifo.sv
hw/smi_readout.sv
hw/iq_rx_top.sv
test/iq_rx_checker.sv
test/tb_iq_rx_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the I/Q receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f compile.f --top-module tb_iq_rx_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
